// File: core_bus_top.f
src/core_bus_pkg.sv
src/axi_pkg.sv
src/core_req_select.sv
src/bus_sequencer.sv
src/clint_timer.sv
src/axi_lane_adapter.sv
src/core_bus_top.sv
verif/core_bus_asserts.sv
verif/core_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f core_bus_top.f --top-module core_bus_tb -o core_bus_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/core_bus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

// File: verif/core_bus_tb.sv
module core_bus_tb;

  localparam int TMO = 200;

  logic                    clk;
  logic                    rst;
  core_bus_pkg::fetch_req_t fetch_req;
  core_bus_pkg::lsu_req_t   lsu_req;
  core_bus_pkg::core_rsp_t  fetch_rsp;
  core_bus_pkg::core_rsp_t  lsu_rsp;
  axi_pkg::axi_ar_t        ar;
  axi_pkg::axi_aw_t        aw;
  axi_pkg::axi_w_t         w;
  axi_pkg::axi_r_t         r;
  axi_pkg::axi_b_t         b;
  logic                    arvalid;
  logic                    awvalid;
  logic                    wvalid;
  logic                    rready;
  logic                    bready;
  logic                    arready = 1'b0;
  logic                    awready = 1'b0;
  logic                    wready = 1'b0;
  logic                    rvalid = 1'b0;
  logic                    bvalid = 1'b0;
  logic [63:0]             rdata = '0;

  logic [63:0]  mem [256];   // slave memory in 64-bit words
  logic [7:0]   ref_mem [2048];
  logic [15:0]  st_st = 16'd54617;
  logic [15:0]  sl_st = 16'd54617;
  logic [1:0]   ar_wait = '0;
  logic [1:0]   r_wait = '0;
  logic [1:0]   aw_wait = '0;
  logic [1:0]   w_wait = '0;
  logic [1:0]   b_wait = '0;
  logic         r_pend = 1'b0;
  logic         aw_got = 1'b0;
  logic         w_got = 1'b0;
  logic [31:0]  rd_addr = '0;
  logic [31:0]  wr_addr = '0;
  logic [63:0]  wr_data = '0;
  logic [7:0]   wr_strb = '0;
  int           errors = 0;
  int           fetch_issued = 0;
  int           lsu_issued = 0;
  int           fetch_seen = 0;
  int           lsu_seen = 0;
  int           ar_hs = 0;
  logic [31:0]  ax_addrs [$];
  core_bus_pkg::access_size_t exp_size = core_bus_pkg::SIZE_WORD;

  assign r = '{data: rdata, resp: axi_pkg::AXI_RESP_OKAY, last: 1'b1, id: 4'd0};
  assign b = '{resp: axi_pkg::AXI_RESP_OKAY, id: 4'd0};

  core_bus_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .lsu_req_i   (lsu_req),
    .fetch_rsp_o (fetch_rsp),
    .lsu_rsp_o   (lsu_rsp),
    .ar_o        (ar),
    .arvalid_o   (arvalid),
    .arready_i   (arready),
    .aw_o        (aw),
    .awvalid_o   (awvalid),
    .awready_i   (awready),
    .w_o         (w),
    .wvalid_o    (wvalid),
    .wready_i    (wready),
    .r_i         (r),
    .rvalid_i    (rvalid),
    .rready_o    (rready),
    .b_i         (b),
    .bvalid_i    (bvalid),
    .bready_o    (bready)
  );

  bind core_bus_top core_bus_asserts u_asserts (
    .clk (clk), .rst (rst), .fetch_req_i (fetch_req_i), .lsu_req_i (lsu_req_i),
    .ar_o (ar_o), .arvalid_o (arvalid_o), .arready_i (arready_i),
    .aw_o (aw_o), .awvalid_o (awvalid_o), .awready_i (awready_i), .w_o (w_o),
    .wvalid_o (wvalid_o), .wready_i (wready_i), .r_i (r_i), .rvalid_i (rvalid_i),
    .b_i (b_i), .bvalid_i (bvalid_i), .fetch_rsp_o (fetch_rsp_o), .lsu_rsp_o (lsu_rsp_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(inout logic [15:0] st, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      st = lfsr_step(st);
      v = {v[30:0], st[0]};
    end
    return v;
  endfunction

  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 29) + ((a >> 8) * 7) + 8'h3c);
  endfunction

  function automatic logic [31:0] ref_load(input logic [31:0] a,
                                           input core_bus_pkg::access_size_t sz);
    int i;
    i = int'(a[10:0]);
    case (sz)
      core_bus_pkg::SIZE_BYTE: return {24'd0, ref_mem[i]};
      core_bus_pkg::SIZE_HALF: return {16'd0, ref_mem[i + 1], ref_mem[i]};
      default: return {ref_mem[i + 3], ref_mem[i + 2], ref_mem[i + 1], ref_mem[i]};
    endcase
  endfunction

  task automatic ref_store(input logic [31:0] a, input logic [31:0] d,
                           input core_bus_pkg::access_size_t sz);
    int n;
    n = (sz == core_bus_pkg::SIZE_BYTE) ? 1 : (sz == core_bus_pkg::SIZE_HALF) ? 2 : 4;
    for (int k = 0; k < n; k++)
      ref_mem[int'(a[10:0]) + k] = d[8*k +: 8];
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // AXI slave with 0..3 cycle delays
  always @(posedge clk)
  begin : slave
    logic [63:0] word;
    if (rst)
    begin
      arready <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      rvalid  <= 1'b0;
      bvalid  <= 1'b0;
      r_pend  <= 1'b0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      for (int i = 0; i < 256; i++)
      begin
        for (int k = 0; k < 8; k++)
          word[8*k +: 8] = fill_byte(i * 8 + k);
        mem[i] <= word;
      end
    end
    else
    begin
      if (arvalid && arready)
      begin
        arready <= 1'b0;
        r_pend  <= 1'b1;
        rd_addr <= ar.addr;
        r_wait  <= 2'(rand_bits(sl_st, 2));
        ar_wait <= 2'(rand_bits(sl_st, 2));
      end
      else if (arvalid)
      begin
        if (ar_wait == 2'd0)
          arready <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end
      rvalid <= 1'b0;
      if (r_pend && !rvalid)
      begin
        if (r_wait == 2'd0)
        begin
          rvalid <= 1'b1;
          rdata  <= mem[rd_addr[10:3]];
          r_pend <= 1'b0;
        end
        else
          r_wait <= r_wait - 2'd1;
      end
      if (awvalid && awready)
      begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        wr_addr <= aw.addr;
        aw_wait <= 2'(rand_bits(sl_st, 2));
        b_wait  <= 2'(rand_bits(sl_st, 2));
      end
      else if (awvalid)
      begin
        if (aw_wait == 2'd0)
          awready <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end
      if (wvalid && wready)
      begin
        wready  <= 1'b0;
        w_got   <= 1'b1;
        wr_data <= w.data;
        wr_strb <= w.strb;
        w_wait  <= 2'(rand_bits(sl_st, 2));
      end
      else if (wvalid)
      begin
        if (w_wait == 2'd0)
          wready <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end
      bvalid <= 1'b0;
      if (aw_got && w_got && !bvalid)
      begin
        if (b_wait == 2'd0)
        begin
          word = mem[wr_addr[10:3]];
          for (int k = 0; k < 8; k++)
            if (wr_strb[k])
              word[8*k +: 8] = wr_data[8*k +: 8];
          mem[wr_addr[10:3]] <= word;
          bvalid <= 1'b1;
          aw_got <= 1'b0;
          w_got  <= 1'b0;
        end
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

  always @(posedge clk)
  begin
    if (fetch_rsp.valid)
      fetch_seen <= fetch_seen + 1;
    if (lsu_rsp.valid)
      lsu_seen <= lsu_seen + 1;
    if (rvalid)
      check("rready", 64'd1, 64'(rready));
    if (bvalid)
      check("bready", 64'd1, 64'(bready));
    if (arvalid && arready)
    begin
      ar_hs <= ar_hs + 1;
      ax_addrs.push_back(ar.addr);
      check("ar fields", 64'({8'd0, axi_pkg::AXI_BURST_INCR, 4'd0, 3'(exp_size)}),
            64'({ar.len, ar.burst, ar.id, ar.size}));
    end
    if (awvalid && awready)
    begin
      ax_addrs.push_back(aw.addr);
      check("aw fields", 64'({8'd0, axi_pkg::AXI_BURST_INCR, 4'd0, 3'(exp_size)}),
            64'({aw.len, aw.burst, aw.id, aw.size}));
    end
    if (wvalid && wready)
      check("w last", 64'd1, 64'(w.last));
  end

  task automatic fetch_word(input logic [31:0] a);
    int t;
    t = 0;
    @(posedge clk);
    exp_size = core_bus_pkg::SIZE_WORD;
    fetch_req <= '{valid: 1'b1, addr: a};
    fetch_issued++;
    do
    begin
      @(posedge clk);
      t++;
    end while (!fetch_rsp.valid && t < TMO);
    if (!fetch_rsp.valid)
    begin
      $display("timeout: fetch response never came for address %h", a);
      errors++;
    end
    else
      check("fetch", {32'd0, ref_load(a, core_bus_pkg::SIZE_WORD)}, {32'd0, fetch_rsp.data});
    fetch_req.valid <= 1'b0;
  endtask

  task automatic lsu_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                            input core_bus_pkg::access_size_t sz,
                            output logic [31:0] data, output int lat);
    int t;
    int t_grant;
    t = 0;
    t_grant = -1;
    data = '0;
    lat = -1;
    @(posedge clk);
    exp_size = sz;
    lsu_req <= '{valid: 1'b1, write: wr, addr: a, wdata: d, size: sz};
    lsu_issued++;
    do
    begin
      @(posedge clk);
      t++;
      if (dut_i.seq_grant && t_grant < 0)
        t_grant = t;
    end while (!lsu_rsp.valid && t < TMO);
    if (!lsu_rsp.valid)
    begin
      $display("timeout: load/store response never came for address %h", a);
      errors++;
    end
    else
    begin
      data = lsu_rsp.data;
      lat = t - t_grant;
    end
    lsu_req.valid <= 1'b0;
  endtask

  // fetch and load/store raised in the same cycle
  task automatic pair_access(input logic [31:0] la, input core_bus_pkg::access_size_t sz,
                             input logic [31:0] fa);
    int  t;
    int  first;
    bit  f_done;
    bit  l_done;
    t = 0;
    f_done = 0;
    l_done = 0;
    first = ax_addrs.size();
    @(posedge clk);
    exp_size = sz;
    lsu_req   <= '{valid: 1'b1, write: 1'b0, addr: la, wdata: 32'd0, size: sz};
    fetch_req <= '{valid: 1'b1, addr: fa};
    lsu_issued++;
    fetch_issued++;
    while (!(f_done && l_done) && t < TMO)
    begin
      @(posedge clk);
      t++;
      if (lsu_rsp.valid)
      begin
        check("pair lsu", {32'd0, ref_load(la, sz)}, {32'd0, lsu_rsp.data});
        lsu_req.valid <= 1'b0;
        l_done = 1;
        exp_size = core_bus_pkg::SIZE_WORD;
      end
      if (fetch_rsp.valid)
      begin
        check("pair order", 64'd1, {63'd0, l_done});
        check("pair fetch", {32'd0, ref_load(fa, core_bus_pkg::SIZE_WORD)},
              {32'd0, fetch_rsp.data});
        fetch_req.valid <= 1'b0;
        f_done = 1;
      end
    end
    if (!(f_done && l_done))
    begin
      $display("timeout: a response of the paired fetch and load never came");
      errors++;
    end
    else
      check("pair first addr", {32'd0, la}, {32'd0, ax_addrs[first]});
  endtask

  initial
  begin : stim
    logic [31:0]              a;
    logic [31:0]              d;
    logic [31:0]              got;
    logic [31:0]              lo;
    logic [63:0]              cnt;
    logic [63:0]              prev;
    logic                     wr;
    int                       lat;
    int                       ar_before;
    core_bus_pkg::access_size_t sz;
    rst = 1'b1;
    fetch_req = '0;
    lsu_req = '0;
    prev = '0;
    for (int i = 0; i < 2048; i++)
      ref_mem[i] = fill_byte(i);
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 20; i++)
      fetch_word({21'd0, 11'(rand_bits(st_st, 11)) & 11'h7fc});

    for (int i = 0; i < 60; i++)
    begin
      wr = rand_bits(st_st, 1) != 0;
      case (2'(rand_bits(st_st, 2)))
        2'd0: sz = core_bus_pkg::SIZE_BYTE;
        2'd1: sz = core_bus_pkg::SIZE_HALF;
        default: sz = core_bus_pkg::SIZE_WORD;
      endcase
      a = {21'd0, 11'(rand_bits(st_st, 11))};
      if (sz == core_bus_pkg::SIZE_HALF)
        a[0] = 1'b0;
      else if (sz == core_bus_pkg::SIZE_WORD)
        a[1:0] = 2'b00;
      d = rand_bits(st_st, 32);
      lsu_access(wr, a, d, sz, got, lat);
      if (wr)
      begin
        check("store rsp", 64'd0, {32'd0, got});
        ref_store(a, d, sz);
      end
      else
        check("load", {32'd0, ref_load(a, sz)}, {32'd0, got});
    end

    for (int i = 0; i < 4; i++)
      pair_access({21'd0, 11'(rand_bits(st_st, 11)) & 11'h7fc}, core_bus_pkg::SIZE_WORD,
                  {21'd0, 11'(rand_bits(st_st, 11)) & 11'h7fc});

    for (int i = 0; i < 6; i++)
    begin
      @(posedge clk);
      ar_before = ar_hs;
      lsu_access(1'b0, core_bus_pkg::CLINT_MTIME_LO, 32'd0, core_bus_pkg::SIZE_WORD, lo, lat);
      check("timer lo latency", 64'd2, 64'(lat));
      lsu_access(1'b0, core_bus_pkg::CLINT_MTIME_HI, 32'd0, core_bus_pkg::SIZE_WORD, got, lat);
      check("timer hi latency", 64'd2, 64'(lat));
      @(posedge clk);
      check("timer no AR", 64'(ar_before), 64'(ar_hs));
      cnt = {got, lo};
      if (cnt < prev)
      begin
        $display("mtime went backwards from %h to %h", prev, cnt);
        errors++;
      end
      prev = cnt;
    end

    repeat (5) @(posedge clk);
    check("fetch rsp count", 64'(fetch_issued), 64'(fetch_seen));
    check("lsu rsp count", 64'(lsu_issued), 64'(lsu_seen));
    $display("errors: %0d  fetches: %0d  load/stores: %0d", errors, fetch_issued, lsu_issued);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: verif/core_bus_asserts.sv
module core_bus_asserts (
  input logic                     clk,
  input logic                     rst,
  input core_bus_pkg::fetch_req_t fetch_req_i,
  input core_bus_pkg::lsu_req_t   lsu_req_i,
  input axi_pkg::axi_ar_t         ar_o,
  input logic                     arvalid_o,
  input logic                     arready_i,
  input axi_pkg::axi_aw_t         aw_o,
  input logic                     awvalid_o,
  input logic                     awready_i,
  input axi_pkg::axi_w_t          w_o,
  input logic                     wvalid_o,
  input logic                     wready_i,
  input axi_pkg::axi_r_t          r_i,
  input logic                     rvalid_i,
  input axi_pkg::axi_b_t          b_i,
  input logic                     bvalid_i,
  input core_bus_pkg::core_rsp_t  fetch_rsp_o,
  input core_bus_pkg::core_rsp_t  lsu_rsp_o
);

  ar_stable: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else $error("AR valid or payload changed before ready");

  aw_stable: assert property (@(posedge clk) disable iff (rst)
    awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
    else $error("AW valid or payload changed before ready");

  w_stable: assert property (@(posedge clk) disable iff (rst)
    wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
    else $error("W valid or payload changed before ready");

  // response only to a port that is asking
  fetch_rsp_owner: assert property (@(posedge clk) disable iff (rst)
    fetch_rsp_o.valid |-> fetch_req_i.valid)
    else $error("fetch response without a pending fetch request");

  lsu_rsp_owner: assert property (@(posedge clk) disable iff (rst)
    lsu_rsp_o.valid |-> lsu_req_i.valid)
    else $error("load/store response without a pending load/store request");

  r_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> r_i.resp == axi_pkg::AXI_RESP_OKAY)
    else $error("read response not OKAY");

  b_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> b_i.resp == axi_pkg::AXI_RESP_OKAY)
    else $error("write response not OKAY");

endmodule

// File: src/core_bus_top.sv
module core_bus_top (
  input  logic                     clk,
  input  logic                     rst,
  input  core_bus_pkg::fetch_req_t fetch_req_i,
  input  core_bus_pkg::lsu_req_t   lsu_req_i,
  output core_bus_pkg::core_rsp_t  fetch_rsp_o,
  output core_bus_pkg::core_rsp_t  lsu_rsp_o,
  output axi_pkg::axi_ar_t         ar_o,
  output logic                     arvalid_o,
  input  logic                     arready_i,
  output axi_pkg::axi_aw_t         aw_o,
  output logic                     awvalid_o,
  input  logic                     awready_i,
  output axi_pkg::axi_w_t          w_o,
  output logic                     wvalid_o,
  input  logic                     wready_i,
  input  axi_pkg::axi_r_t          r_i,
  input  logic                     rvalid_i,
  output logic                     rready_o,
  input  axi_pkg::axi_b_t          b_i,
  input  logic                     bvalid_i,
  output logic                     bready_o
);

  logic                   sel_valid;
  core_bus_pkg::bus_req_t sel_req;
  logic                   seq_grant;
  logic                   done_valid;
  logic [31:0]            done_data;
  core_bus_pkg::bus_req_t act_req;
  logic [31:0]            rd_word;
  logic                   tmr_rd;
  logic                   tmr_hi;
  logic [31:0]            tmr_rdata;

  // responses are always accepted, b_i carries only status
  assign rready_o = 1'b1;
  assign bready_o = 1'b1;

  core_req_select u_select (
    .clk          (clk),
    .rst          (rst),
    .fetch_req_i  (fetch_req_i),
    .lsu_req_i    (lsu_req_i),
    .seq_grant_i  (seq_grant),
    .done_valid_i (done_valid),
    .done_data_i  (done_data),
    .sel_valid_o  (sel_valid),
    .sel_req_o    (sel_req),
    .fetch_rsp_o  (fetch_rsp_o),
    .lsu_rsp_o    (lsu_rsp_o)
  );

  bus_sequencer u_seq (
    .clk          (clk),
    .rst          (rst),
    .sel_valid_i  (sel_valid),
    .sel_req_i    (sel_req),
    .seq_grant_o  (seq_grant),
    .act_req_o    (act_req),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .rvalid_i     (rvalid_i),
    .bvalid_i     (bvalid_i),
    .rd_word_i    (rd_word),
    .tmr_rd_o     (tmr_rd),
    .tmr_hi_o     (tmr_hi),
    .tmr_rdata_i  (tmr_rdata),
    .done_valid_o (done_valid),
    .done_data_o  (done_data)
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (tmr_rd),
    .hi_i    (tmr_hi),
    .rdata_o (tmr_rdata)
  );

  axi_lane_adapter u_lanes (
    .act_req_i (act_req),
    .r_i       (r_i),
    .ar_o      (ar_o),
    .aw_o      (aw_o),
    .w_o       (w_o),
    .rd_word_o (rd_word)
  );

endmodule

// File: src/axi_lane_adapter.sv
module axi_lane_adapter (
  input  core_bus_pkg::bus_req_t act_req_i,
  input  axi_pkg::axi_r_t        r_i,
  output axi_pkg::axi_ar_t       ar_o,
  output axi_pkg::axi_aw_t       aw_o,
  output axi_pkg::axi_w_t        w_o,
  output logic [31:0]           rd_word_o
);

  logic [1:0]       off;
  logic             lane_hi;
  logic [2:0]       ax_size;
  logic [3:0]       strb_base;
  logic [3:0]       strb_sh;
  logic [31:0]      wdata_sh;
  logic [31:0]      rd_lane;
  logic [31:0]      rd_sh;
  axi_pkg::axi_ar_t ax;

  assign off     = act_req_i.addr[1:0];
  assign lane_hi = act_req_i.addr[2];

  always_comb
  begin
    case (act_req_i.size)
      core_bus_pkg::SIZE_BYTE:
      begin
        ax_size   = axi_pkg::AXI_SIZE_1B;
        strb_base = 4'b0001;
      end
      core_bus_pkg::SIZE_HALF:
      begin
        ax_size   = axi_pkg::AXI_SIZE_2B;
        strb_base = 4'b0011;
      end
      default:
      begin
        ax_size   = axi_pkg::AXI_SIZE_4B;
        strb_base = 4'b1111;
      end
    endcase
  end

  // single beat, id 0
  assign ax.addr  = act_req_i.addr;
  assign ax.len   = 8'd0;
  assign ax.size  = ax_size;
  assign ax.burst = axi_pkg::AXI_BURST_INCR;
  assign ax.id    = 4'd0;
  assign ar_o     = ax;
  assign aw_o     = ax;

  assign wdata_sh  = act_req_i.wdata << {off, 3'b000};
  assign strb_sh   = strb_base << off;
  assign w_o.data  = {wdata_sh, wdata_sh};  // strobe picks the lane
  assign w_o.strb  = lane_hi ? {strb_sh, 4'b0000} : {4'b0000, strb_sh};
  assign w_o.last  = 1'b1;

  assign rd_lane = lane_hi ? r_i.data[63:32] : r_i.data[31:0];
  assign rd_sh   = rd_lane >> {off, 3'b000};

  always_comb
  begin
    case (act_req_i.size)
      core_bus_pkg::SIZE_BYTE: rd_word_o = {24'd0, rd_sh[7:0]};
      core_bus_pkg::SIZE_HALF: rd_word_o = {16'd0, rd_sh[15:0]};
      default:                 rd_word_o = rd_sh;
    endcase
  end

endmodule

// File: src/clint_timer.sv
module clint_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_i,
  input  logic        hi_i,
  output logic [31:0] rdata_o
);

  core_bus_pkg::mtime_u mtime;

  // free running from reset
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime.count <= '0;
    else
      mtime.count <= mtime.count + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_o <= hi_i ? mtime.half.hi : mtime.half.lo;
  end

endmodule

// File: src/bus_sequencer.sv
module bus_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  sel_valid_i,
  input  core_bus_pkg::bus_req_t sel_req_i,
  output logic                  seq_grant_o,
  output core_bus_pkg::bus_req_t act_req_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output logic                  wvalid_o,
  input  logic                  wready_i,
  input  logic                  rvalid_i,
  input  logic                  bvalid_i,
  input  logic [31:0]           rd_word_i,
  output logic                  tmr_rd_o,
  output logic                  tmr_hi_o,
  input  logic [31:0]           tmr_rdata_i,
  output logic                  done_valid_o,
  output logic [31:0]           done_data_o
);

  typedef enum logic [2:0] {IDLE, READ_ADDR, READ_DATA, WRITE, TIMER} state_t;

  state_t state;
  logic   timer_hit;
  logic   aw_done;
  logic   w_done;
  logic   wr_finish;

  assign timer_hit = !sel_req_i.write &&
                     (sel_req_i.addr == core_bus_pkg::CLINT_MTIME_LO ||
                      sel_req_i.addr == core_bus_pkg::CLINT_MTIME_HI);

  // requester still holds the old request while its response is out
  assign seq_grant_o = (state == IDLE) && sel_valid_i && !done_valid_o;

  assign tmr_rd_o  = seq_grant_o && timer_hit;
  assign tmr_hi_o  = sel_req_i.addr == core_bus_pkg::CLINT_MTIME_HI;
  assign wr_finish = (state == WRITE) && bvalid_i && aw_done && w_done;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= IDLE;
      arvalid_o    <= 1'b0;
      awvalid_o    <= 1'b0;
      wvalid_o     <= 1'b0;
      aw_done      <= 1'b0;
      w_done       <= 1'b0;
      done_valid_o <= 1'b0;
    end
    else
    begin
      done_valid_o <= 1'b0;
      case (state)
        IDLE:
        begin
          if (seq_grant_o)
          begin
            if (timer_hit)
              state <= TIMER;  // never reaches the bus
            else if (sel_req_i.write)
            begin
              state     <= WRITE;
              awvalid_o <= 1'b1;
              wvalid_o  <= 1'b1;
              aw_done   <= 1'b0;
              w_done    <= 1'b0;
            end
            else
            begin
              state     <= READ_ADDR;
              arvalid_o <= 1'b1;
            end
          end
        end
        READ_ADDR:
        begin
          if (arready_i)
          begin
            arvalid_o <= 1'b0;
            state     <= READ_DATA;
          end
        end
        READ_DATA:
        begin
          if (rvalid_i)
          begin
            done_valid_o <= 1'b1;
            state        <= IDLE;
          end
        end
        WRITE:
        begin
          if (awvalid_o && awready_i)
          begin
            awvalid_o <= 1'b0;
            aw_done   <= 1'b1;
          end
          if (wvalid_o && wready_i)
          begin
            wvalid_o <= 1'b0;
            w_done   <= 1'b1;
          end
          if (wr_finish)
          begin
            done_valid_o <= 1'b1;
            state        <= IDLE;
          end
        end
        TIMER:
        begin
          done_valid_o <= 1'b1;  // timer data arrived this cycle
          state        <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (seq_grant_o)
      act_req_o <= sel_req_i;
    if (state == READ_DATA && rvalid_i)
      done_data_o <= rd_word_i;
    else if (state == TIMER)
      done_data_o <= tmr_rdata_i;
    else if (wr_finish)
      done_data_o <= '0;
  end

endmodule

// File: src/core_req_select.sv
module core_req_select (
  input  logic                    clk,
  input  logic                    rst,
  input  core_bus_pkg::fetch_req_t fetch_req_i,
  input  core_bus_pkg::lsu_req_t   lsu_req_i,
  input  logic                    seq_grant_i,
  input  logic                    done_valid_i,
  input  logic [31:0]             done_data_i,
  output logic                    sel_valid_o,
  output core_bus_pkg::bus_req_t   sel_req_o,
  output core_bus_pkg::core_rsp_t  fetch_rsp_o,
  output core_bus_pkg::core_rsp_t  lsu_rsp_o
);

  logic src_lsu_q;  // owner of the transaction in flight

  assign sel_valid_o = lsu_req_i.valid || fetch_req_i.valid;

  always_comb
  begin
    if (lsu_req_i.valid)
    begin
      sel_req_o.write   = lsu_req_i.write;
      sel_req_o.addr    = lsu_req_i.addr;
      sel_req_o.wdata   = lsu_req_i.wdata;
      sel_req_o.size    = lsu_req_i.size;
      sel_req_o.src_lsu = 1'b1;
    end
    else
    begin
      // fetch is always a word read
      sel_req_o.write   = 1'b0;
      sel_req_o.addr    = fetch_req_i.addr;
      sel_req_o.wdata   = '0;
      sel_req_o.size    = core_bus_pkg::SIZE_WORD;
      sel_req_o.src_lsu = 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      src_lsu_q <= 1'b0;
    else if (seq_grant_i)
      src_lsu_q <= sel_req_o.src_lsu;
  end

  assign fetch_rsp_o.valid = done_valid_i && !src_lsu_q;
  assign fetch_rsp_o.data  = done_data_i;
  assign lsu_rsp_o.valid   = done_valid_i && src_lsu_q;
  assign lsu_rsp_o.data    = done_data_i;

endmodule

// File: src/axi_pkg.sv
package axi_pkg;

  localparam logic [2:0] AXI_SIZE_1B = 3'd0;
  localparam logic [2:0] AXI_SIZE_2B = 3'd1;
  localparam logic [2:0] AXI_SIZE_4B = 3'd2;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  // address channel payload
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
    logic [3:0]  id;
  } axi_ar_t;

  typedef axi_ar_t axi_aw_t;  // same fields as AR

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [63:0] data;
    logic [1:0]  resp;
    logic        last;
    logic [3:0]  id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic [3:0] id;
  } axi_b_t;

endpackage

// File: src/core_bus_pkg.sv
package core_bus_pkg;

  // same codes as AXI size 0..2
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_t;

  // instruction fetch request, word aligned
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic         valid;
    logic         write;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    access_size_t size;
  } lsu_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;  // zero for stores
  } core_rsp_t;

  // request chosen by the selector
  typedef struct packed {
    logic         write;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    access_size_t size;
    logic         src_lsu;  // 0 means fetch
  } bus_req_t;

  typedef union packed {
    logic [63:0] count;
    struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
    } half;
  } mtime_u;

  localparam logic [31:0] CLINT_MTIME_LO = 32'h0200_bff8;
  localparam logic [31:0] CLINT_MTIME_HI = 32'h0200_bffc;

endpackage
